// ==== bwp_rx_top.f ====
hdl/nr_rx_pkg.sv
hdl/symbol_tagger.sv
hdl/bwp_extractor.sv
hdl/antenna_combiner.sv
hdl/bwp_rx_top.sv
bench/bwp_rx_top_tb.sv

// ==== bench/bwp_rx_top_tb.sv ====
`timescale 1ns/1ps

module bwp_rx_top_tb;

    localparam int FFT_LEN      = nr_rx_pkg::FFT_LEN;
    localparam int IN_DW        = nr_rx_pkg::IN_DW;
    localparam int IQ_W         = nr_rx_pkg::IQ_W;
    localparam int LATENCY      = 3;
    localparam int RESET_CYCLES = 5;
    localparam int MODE_RANDOM  = 0;
    localparam int MODE_EXTREME = 1;
    localparam int MODE_GAPS    = 2;
    // 25 symbols in all, two of them with gaps of up to one cycle per strobe
    localparam int STIM_CYCLES  = 27 * FFT_LEN + RESET_CYCLES + 60;
    localparam int TIMEOUT      = STIM_CYCLES * 3 / 2 + 100;

    logic                                   clk_i = 1'b0;
    logic                                   reset_ni;
    logic                                   in_valid;
    logic [nr_rx_pkg::NUM_ANT*IN_DW-1:0]    in_data;
    logic [nr_rx_pkg::BLK_EXP_LEN-1:0]      in_blk_exp;
    logic                                   out_valid;
    logic [nr_rx_pkg::OUT_DW-1:0]           out_data;
    logic [nr_rx_pkg::USER_OUT_W-1:0]       out_user;
    logic                                   out_last;
    logic                                   pbch_valid;
    logic                                   sss_valid;

    logic [15:0]                       lfsr = 16'd15;
    logic [nr_rx_pkg::BLK_EXP_LEN-1:0] sym_exp;
    int cyc = 0;
    int sample_idx = 0;
    int errors = 0;
    int out_count = 0;
    int tests = 0;

    // Expected kept samples in output order
    int                               exp_cycle_q[$];
    logic [nr_rx_pkg::OUT_DW-1:0]     exp_data_q[$];
    logic [nr_rx_pkg::USER_OUT_W-1:0] exp_user_q[$];
    logic [2:0]                       exp_flags_q[$];

    bwp_rx_top dut0 (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_blk_exp (in_blk_exp),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_user   (out_user),
        .out_last   (out_last),
        .pbch_valid (pbch_valid),
        .sss_valid  (sss_valid)
    );

    always #5 clk_i = ~clk_i;

    ////////////////////
    // Random bits

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            val = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    ////////////////////
    // Reference model

    function automatic logic expect_sample(
        input  int                                  idx,
        input  logic [nr_rx_pkg::NUM_ANT*IN_DW-1:0] din,
        input  logic [nr_rx_pkg::BLK_EXP_LEN-1:0]   bexp,
        output logic [nr_rx_pkg::OUT_DW-1:0]        exp_data,
        output logic [nr_rx_pkg::USER_OUT_W-1:0]    exp_user,
        output logic [2:0]                          exp_flags
    );
        int   sc;
        int   sym_abs;
        int   sym;
        int   sf;
        int   sfn;
        int   si;
        int   sq;
        logic pbch_sym;
        logic sss_sym;
        sc      = idx % FFT_LEN;
        sym_abs = idx / FFT_LEN;
        sym     = sym_abs % nr_rx_pkg::SYM_PER_SF;
        sf      = (sym_abs / nr_rx_pkg::SYM_PER_SF) % nr_rx_pkg::SUBFRAMES_PER_FRAME;
        sfn     = (sym_abs / (nr_rx_pkg::SYM_PER_SF * nr_rx_pkg::SUBFRAMES_PER_FRAME))
                  % (nr_rx_pkg::SFN_MAX + 1);
        si = 0;
        sq = 0;
        for (int k = 0; k < nr_rx_pkg::NUM_ANT; k++) begin
            si = si + $signed(din[k*IN_DW + IQ_W +: IQ_W]);
            sq = sq + $signed(din[k*IN_DW +: IQ_W]);
        end
        // PBCH in symbols 3 to 5 and SSS in symbol 4, both of subframe 0
        pbch_sym = (sf == 0) && (sym >= 3) && (sym <= 5);
        sss_sym  = (sf == 0) && (sym == 4);
        exp_data = {si[nr_rx_pkg::OUT_IQ_W-1:0], sq[nr_rx_pkg::OUT_IQ_W-1:0]};
        exp_user = {sfn[nr_rx_pkg::SFN_W-1:0], sf[nr_rx_pkg::SF_W-1:0],
                    sym[nr_rx_pkg::SYM_W-1:0], bexp, pbch_sym};
        exp_flags[2] = (sc == nr_rx_pkg::SC_END - 1);
        exp_flags[1] = pbch_sym && (sc >= nr_rx_pkg::PBCH_START)
                       && (sc < nr_rx_pkg::PBCH_START + nr_rx_pkg::PBCH_LEN);
        exp_flags[0] = sss_sym && (sc >= nr_rx_pkg::SSS_START)
                       && (sc < nr_rx_pkg::SSS_START + nr_rx_pkg::SSS_LEN);
        return (sc >= nr_rx_pkg::SC_START) && (sc < nr_rx_pkg::SC_END);
    endfunction

    ////////////////////
    // Checks

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_quiet(input string when_txt);
        assert (out_valid === 1'b0 && out_last === 1'b0 && pbch_valid === 1'b0
                && sss_valid === 1'b0) else begin
            $display("A valid, last or flag output is high or unknown %s", when_txt);
            errors++;
        end
    endtask

    // Outputs are read at the rising edge, before the registers update
    always @(posedge clk_i) begin : compare
        if (!reset_ni) begin
            if (cyc >= 1)
                check_quiet("during reset");
        end else if (out_valid === 1'b1) begin
            out_count++;
            if (exp_cycle_q.size() == 0) begin
                $display("Output sample at cycle %0d has no input sample left to match", cyc);
                errors++;
            end else begin
                check_value("latency", cyc - exp_cycle_q.pop_front(), LATENCY);
                check_value("out_data", out_data, exp_data_q.pop_front());
                check_value("out_user", out_user, exp_user_q.pop_front());
                check_value("out_last", out_last, exp_flags_q[0][2]);
                check_value("pbch_valid", pbch_valid, exp_flags_q[0][1]);
                check_value("sss_valid", sss_valid, exp_flags_q[0][0]);
                void'(exp_flags_q.pop_front());
            end
        end else begin
            check_quiet("without a sample");
        end
        cyc <= cyc + 1;
    end

    ////////////////////
    // Stimulus

    task automatic drive_symbols(input int nsym, input int mode);
        logic [31:0]                         bits;
        logic [nr_rx_pkg::NUM_ANT*IN_DW-1:0] din;
        logic [nr_rx_pkg::OUT_DW-1:0]        e_data;
        logic [nr_rx_pkg::USER_OUT_W-1:0]    e_user;
        logic [2:0]                          e_flags;
        logic                                keep;
        for (int n = 0; n < nsym * FFT_LEN; n++) begin
            @(negedge clk_i);
            if (mode == MODE_GAPS) begin
                take_bits(1, bits);
                if (bits[0]) begin
                    in_valid = 1'b0;
                    @(negedge clk_i);
                end
            end
            if (sample_idx % FFT_LEN == 0) begin
                take_bits(nr_rx_pkg::BLK_EXP_LEN, bits);
                sym_exp = bits[nr_rx_pkg::BLK_EXP_LEN-1:0];
            end
            for (int k = 0; k < nr_rx_pkg::NUM_ANT; k++) begin
                take_bits(IN_DW, bits);
                // Full-scale corners on three of every four samples
                if (mode == MODE_EXTREME && n % 4 == 0)
                    bits = 16'h8080;
                else if (mode == MODE_EXTREME && n % 4 == 1)
                    bits = 16'h7F7F;
                else if (mode == MODE_EXTREME && n % 4 == 2)
                    bits = (k % 2 == 0) ? 16'h807F : 16'h7F80;
                din[k*IN_DW +: IN_DW] = bits[IN_DW-1:0];
            end
            in_valid   = 1'b1;
            in_data    = din;
            in_blk_exp = (sample_idx % FFT_LEN == 0) ? sym_exp : ~sym_exp;
            keep = expect_sample(sample_idx, din, sym_exp, e_data, e_user, e_flags);
            if (keep) begin
                exp_cycle_q.push_back(cyc);
                exp_data_q.push_back(e_data);
                exp_user_q.push_back(e_user);
                exp_flags_q.push_back(e_flags);
            end
            sample_idx++;
        end
        @(negedge clk_i);
        in_valid = 1'b0;
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors == err0)
            $display("%-14s ok", name);
        else
            $display("%-14s failed with %0d errors", name, errors - err0);
    endtask

    task automatic run_test(input string name, input int nsym, input int mode);
        int err0;
        int out0;
        err0 = errors;
        out0 = out_count;
        drive_symbols(nsym, mode);
        while (exp_cycle_q.size() != 0)
            @(negedge clk_i);
        repeat (4) @(negedge clk_i);
        check_value("kept sample count", out_count - out0, nsym * nr_rx_pkg::BWP_LEN);
        report_test(name, err0);
    endtask

    initial begin
        wait (cyc >= TIMEOUT);
        $display("Timeout after %0d cycles, the output stream did not drain", cyc);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset_ni   = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_blk_exp = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_ni = 1'b1;
        repeat (3) @(negedge clk_i);
        report_test("reset", 0);
        run_test("bwp window", 1, MODE_RANDOM);
        run_test("extreme sums", 1, MODE_EXTREME);
        run_test("pbch and sss", 5, MODE_RANDOM);
        run_test("symbol roll", 16, MODE_RANDOM);
        run_test("random gaps", 2, MODE_GAPS);
        $display("Tests: %0d  samples checked: %0d  errors: %0d", tests, out_count, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== hdl/bwp_rx_top.sv ====
`timescale 1ns/1ps

module bwp_rx_top (
    input  logic                                           clk_i,
    input  logic                                           reset_ni,
    input  logic                                           in_valid,
    input  logic [nr_rx_pkg::NUM_ANT*nr_rx_pkg::IN_DW-1:0] in_data,
    input  logic [nr_rx_pkg::BLK_EXP_LEN-1:0]              in_blk_exp,
    output logic                                           out_valid,
    output logic [nr_rx_pkg::OUT_DW-1:0]                   out_data,
    output logic [nr_rx_pkg::USER_OUT_W-1:0]               out_user,
    output logic                                           out_last,
    output logic                                           pbch_valid,
    output logic                                           sss_valid
);

    localparam int NUM_ANT = nr_rx_pkg::NUM_ANT;
    localparam int IN_DW   = nr_rx_pkg::IN_DW;
    localparam int UW      = nr_rx_pkg::USER_OUT_W;

    logic                            tag_valid;
    logic [NUM_ANT*IN_DW-1:0]        tag_data;
    logic [nr_rx_pkg::USER_IN_W-1:0] tag_user;
    logic                            tag_last;

    logic [NUM_ANT-1:0]       ext_valid;
    logic [NUM_ANT*IN_DW-1:0] ext_data;
    logic [NUM_ANT*UW-1:0]    ext_user;
    logic [NUM_ANT-1:0]       ext_last;
    logic [NUM_ANT-1:0]       ext_pbch;
    logic [NUM_ANT-1:0]       ext_sss;

    symbol_tagger tagger0 (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_blk_exp (in_blk_exp),
        .tag_valid  (tag_valid),
        .tag_data   (tag_data),
        .tag_user   (tag_user),
        .tag_last   (tag_last)
    );

    ////////////////////
    // One extractor per antenna

    for (genvar k = 0; k < NUM_ANT; k++) begin : g_lane
        bwp_extractor extractor (
            .clk_i      (clk_i),
            .reset_ni   (reset_ni),
            .in_valid   (tag_valid),
            .in_data    (tag_data[k*IN_DW +: IN_DW]),
            .in_user    (tag_user),
            .in_last    (tag_last),
            .out_valid  (ext_valid[k]),
            .out_data   (ext_data[k*IN_DW +: IN_DW]),
            .out_user   (ext_user[k*UW +: UW]),
            .out_last   (ext_last[k]),
            .pbch_valid (ext_pbch[k]),
            .sss_valid  (ext_sss[k])
        );
    end

    antenna_combiner combiner0 (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .lane_valid (ext_valid),
        .lane_data  (ext_data),
        .lane_user  (ext_user),
        .lane_last  (ext_last),
        .lane_pbch  (ext_pbch),
        .lane_sss   (ext_sss),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_user   (out_user),
        .out_last   (out_last),
        .pbch_valid (pbch_valid),
        .sss_valid  (sss_valid)
    );

endmodule

// ==== hdl/antenna_combiner.sv ====
`timescale 1ns/1ps

module antenna_combiner (
    input  logic                                                clk_i,
    input  logic                                                reset_ni,
    input  logic [nr_rx_pkg::NUM_ANT-1:0]                       lane_valid,
    input  logic [nr_rx_pkg::NUM_ANT*nr_rx_pkg::IN_DW-1:0]      lane_data,
    input  logic [nr_rx_pkg::NUM_ANT*nr_rx_pkg::USER_OUT_W-1:0] lane_user,
    input  logic [nr_rx_pkg::NUM_ANT-1:0]                       lane_last,
    input  logic [nr_rx_pkg::NUM_ANT-1:0]                       lane_pbch,
    input  logic [nr_rx_pkg::NUM_ANT-1:0]                       lane_sss,
    output logic                                                out_valid,
    output logic [nr_rx_pkg::OUT_DW-1:0]                        out_data,
    output logic [nr_rx_pkg::USER_OUT_W-1:0]                    out_user,
    output logic                                                out_last,
    output logic                                                pbch_valid,
    output logic                                                sss_valid
);

    localparam int IQ_W  = nr_rx_pkg::IQ_W;
    localparam int IN_DW = nr_rx_pkg::IN_DW;
    localparam int UW    = nr_rx_pkg::USER_OUT_W;

    logic signed [nr_rx_pkg::OUT_IQ_W-1:0] sum_i;
    logic signed [nr_rx_pkg::OUT_IQ_W-1:0] sum_q;
    logic                                  tags_match;

    ////////////////////
    // Lane sum

    // Signed parts are sign extended into the wider accumulator
    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int k = 0; k < nr_rx_pkg::NUM_ANT; k++) begin
            sum_i = sum_i + $signed(lane_data[k*IN_DW + IQ_W +: IQ_W]);
            sum_q = sum_q + $signed(lane_data[k*IN_DW +: IQ_W]);
        end
    end

    // Tags of every lane against lane 0
    always_comb begin
        tags_match = 1'b1;
        for (int k = 1; k < nr_rx_pkg::NUM_ANT; k++) begin
            if (lane_user[k*UW +: UW] != lane_user[UW-1:0] || lane_last[k] != lane_last[0]
                || lane_pbch[k] != lane_pbch[0] || lane_sss[k] != lane_sss[0])
                tags_match = 1'b0;
        end
    end

    ////////////////////
    // Output register

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            pbch_valid <= 1'b0;
            sss_valid  <= 1'b0;
        end else begin
            out_valid  <= lane_valid[0];
            out_last   <= lane_last[0];
            pbch_valid <= lane_pbch[0];
            sss_valid  <= lane_sss[0];
        end
    end

    always_ff @(posedge clk_i) begin
        out_data <= {sum_i, sum_q};
        out_user <= lane_user[UW-1:0];
    end

    // Antennas run in lockstep
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        (&lane_valid) || !(|lane_valid));

    assert property (@(posedge clk_i) disable iff (!reset_ni) lane_valid[0] |-> tags_match);

endmodule

// ==== hdl/bwp_extractor.sv ====
`timescale 1ns/1ps

module bwp_extractor (
    input  logic                             clk_i,
    input  logic                             reset_ni,
    input  logic                             in_valid,
    input  logic [nr_rx_pkg::IN_DW-1:0]      in_data,
    input  logic [nr_rx_pkg::USER_IN_W-1:0]  in_user,
    input  logic                             in_last,
    output logic                             out_valid,
    output logic [nr_rx_pkg::IN_DW-1:0]      out_data,
    output logic [nr_rx_pkg::USER_OUT_W-1:0] out_user,
    output logic                             out_last,
    output logic                             pbch_valid,
    output logic                             sss_valid
);

    logic [nr_rx_pkg::NFFT-1:0]  sc_cnt;
    logic [nr_rx_pkg::SYM_W-1:0] sym;
    logic [nr_rx_pkg::SF_W-1:0]  subframe;
    logic                        is_pbch_sym;
    logic                        is_sss_sym;
    logic                        in_bwp;
    logic                        in_pbch_sc;
    logic                        in_sss_sc;

    ////////////////////
    // Decode symbol position

    assign sym      = in_user[nr_rx_pkg::BLK_EXP_LEN +: nr_rx_pkg::SYM_W];
    assign subframe = in_user[nr_rx_pkg::BLK_EXP_LEN + nr_rx_pkg::SYM_W +: nr_rx_pkg::SF_W];

    assign is_pbch_sym = (subframe == '0) && (sym >= nr_rx_pkg::PBCH_SYM_FIRST)
                         && (sym <= nr_rx_pkg::PBCH_SYM_LAST);
    assign is_sss_sym  = (subframe == '0) && (sym == nr_rx_pkg::SSS_SYM);

    assign in_bwp     = (sc_cnt >= nr_rx_pkg::SC_START) && (sc_cnt <= nr_rx_pkg::SC_END - 1);
    assign in_pbch_sc = (sc_cnt >= nr_rx_pkg::PBCH_START)
                        && (sc_cnt <= nr_rx_pkg::PBCH_START + nr_rx_pkg::PBCH_LEN - 1);
    assign in_sss_sc  = (sc_cnt >= nr_rx_pkg::SSS_START)
                        && (sc_cnt <= nr_rx_pkg::SSS_START + nr_rx_pkg::SSS_LEN - 1);

    // Subcarrier index, realigned by in_last
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sc_cnt <= '0;
        end else if (in_valid) begin
            sc_cnt <= in_last ? '0 : sc_cnt + 1'b1;
        end
    end

    ////////////////////
    // Output register

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            pbch_valid <= 1'b0;
            sss_valid  <= 1'b0;
        end else begin
            out_valid  <= in_valid && in_bwp;
            out_last   <= in_valid && (sc_cnt == nr_rx_pkg::SC_END - 1);
            pbch_valid <= in_valid && is_pbch_sym && in_pbch_sc;
            sss_valid  <= in_valid && is_sss_sym && in_sss_sc;
        end
    end

    always_ff @(posedge clk_i) begin
        out_data <= in_data;
        out_user <= {in_user, is_pbch_sym};
    end

    // Tagger and extractor agree on where a symbol ends
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        (in_valid && in_last) |-> (sc_cnt == nr_rx_pkg::FFT_LEN - 1));

endmodule

// ==== hdl/symbol_tagger.sv ====
`timescale 1ns/1ps

module symbol_tagger (
    input  logic                                           clk_i,
    input  logic                                           reset_ni,
    input  logic                                           in_valid,
    input  logic [nr_rx_pkg::NUM_ANT*nr_rx_pkg::IN_DW-1:0] in_data,
    input  logic [nr_rx_pkg::BLK_EXP_LEN-1:0]              in_blk_exp,
    output logic                                           tag_valid,
    output logic [nr_rx_pkg::NUM_ANT*nr_rx_pkg::IN_DW-1:0] tag_data,
    output logic [nr_rx_pkg::USER_IN_W-1:0]                tag_user,
    output logic                                           tag_last
);

    logic [nr_rx_pkg::NFFT-1:0]        sample_cnt;
    logic [nr_rx_pkg::SYM_W-1:0]       sym_cnt;
    logic [nr_rx_pkg::SF_W-1:0]        sf_cnt;
    logic [nr_rx_pkg::SFN_W-1:0]       sfn_cnt;
    logic [nr_rx_pkg::BLK_EXP_LEN-1:0] blk_exp_q;
    logic [nr_rx_pkg::BLK_EXP_LEN-1:0] blk_exp_cur;
    logic                              sym_end;

    assign sym_end = (sample_cnt == nr_rx_pkg::FFT_LEN - 1);

    // First sample of a symbol carries its own exponent
    assign blk_exp_cur = (sample_cnt == '0) ? in_blk_exp : blk_exp_q;

    ////////////////////
    // Frame counters

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt <= '0;
            sym_cnt    <= '0;
            sf_cnt     <= '0;
            sfn_cnt    <= '0;
        end else if (in_valid) begin
            sample_cnt <= sym_end ? '0 : sample_cnt + 1'b1;
            if (sym_end) begin
                if (sym_cnt == nr_rx_pkg::SYM_PER_SF - 1) begin
                    sym_cnt <= '0;
                    if (sf_cnt == nr_rx_pkg::SUBFRAMES_PER_FRAME - 1) begin
                        sf_cnt  <= '0;
                        sfn_cnt <= (sfn_cnt == nr_rx_pkg::SFN_MAX) ? '0 : sfn_cnt + 1'b1;
                    end else begin
                        sf_cnt <= sf_cnt + 1'b1;
                    end
                end else begin
                    sym_cnt <= sym_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid && sample_cnt == '0)
            blk_exp_q <= in_blk_exp;
    end

    ////////////////////
    // Output register

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            tag_valid <= 1'b0;
            tag_last  <= 1'b0;
        end else begin
            tag_valid <= in_valid;
            tag_last  <= in_valid && sym_end;
        end
    end

    always_ff @(posedge clk_i) begin
        tag_data <= in_data;
        tag_user <= {sfn_cnt, sf_cnt, sym_cnt, blk_exp_cur};
    end

    // A symbol ends only on a real sample
    assert property (@(posedge clk_i) disable iff (!reset_ni) tag_last |-> tag_valid);

endmodule

// ==== hdl/nr_rx_pkg.sv ====
package nr_rx_pkg;

    ////////////////////
    // Array and sample format

    localparam int NUM_ANT  = 2;
    localparam int NFFT     = 8;
    localparam int FFT_LEN  = 2 ** NFFT;
    localparam int IQ_W     = 8;
    // I in the upper half, Q in the lower half
    localparam int IN_DW    = 2 * IQ_W;
    // One extra bit per doubling of the lane count
    localparam int OUT_IQ_W = IQ_W + $clog2(NUM_ANT);
    localparam int OUT_DW   = 2 * OUT_IQ_W;

    ////////////////////
    // Subcarrier windows

    localparam int SYMBOLS_PER_PRB = 12;
    localparam int NUM_PRB         = 20;
    localparam int BWP_LEN         = NUM_PRB * SYMBOLS_PER_PRB;
    localparam int SC_START        = FFT_LEN / 2 - BWP_LEN / 2;
    localparam int SC_END          = SC_START + BWP_LEN;
    localparam int SSS_LEN         = 127;
    localparam int SSS_START       = FFT_LEN / 2 - (SSS_LEN + 1) / 2;
    localparam int PBCH_LEN        = NUM_PRB * SYMBOLS_PER_PRB;
    localparam int PBCH_START      = FFT_LEN / 2 - PBCH_LEN / 2;

    // SS/PBCH block position inside subframe 0
    localparam int PBCH_SYM_FIRST  = 3;
    localparam int PBCH_SYM_LAST   = 5;
    localparam int SSS_SYM         = 4;

    ////////////////////
    // Frame timing and user field

    localparam int SYM_PER_SF          = 14;
    localparam int SUBFRAMES_PER_FRAME = 20;
    localparam int SFN_MAX             = 1023;

    localparam int SFN_W       = $clog2(SFN_MAX + 1);
    localparam int SF_W        = $clog2(SUBFRAMES_PER_FRAME);
    localparam int SYM_W       = $clog2(SYM_PER_SF);
    localparam int BLK_EXP_LEN = 8;

    // {sfn, subframe, symbol, blk_exp} from the top down
    localparam int USER_IN_W  = SFN_W + SF_W + SYM_W + BLK_EXP_LEN;
    localparam int USER_OUT_W = USER_IN_W + 1;

endpackage
